// File: tb.f
hw/mcu_pkg.sv
hw/wb_decoder.sv
hw/ao_ctrl_regs.sv
hw/gpio_ao.sv
hw/rv_timer.sv
hw/mini_mcu_top.sv
dv/tb_mini_mcu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_mini_mcu -o tb_mini_mcu

out=$(./obj_dir/tb_mini_mcu)
echo "$out"

if echo "$out" | grep -qxF "=== PASS ==="; then
  exit 0
fi
exit 1

// File: dv/tb_mini_mcu.sv
// ~~~~~~~~~~~~~~~~~~~~
// One Wishbone access at a time, pins start low after reset
// Switch ack model answers 3 cycles after periph_switch_o changes
// ~~~~~~~~~~~~~~~~~~~~
module tb_mini_mcu
  import mcu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // About 45 accesses of 4 cycles plus the timer and power waits stay well below
  localparam int TIMEOUT_CYCLES = 2000;

  logic  clk_i = 1'b0;
  logic  rst_n_i;
  logic  wb_cyc_i;
  logic  wb_stb_i;
  logic  wb_we_i;
  addr_t wb_adr_i;
  word_t wb_dat_i;
  word_t wb_dat_o;
  logic  wb_ack_o;
  logic  wb_err_o;
  logic  boot_select_i;
  gpio_t gpio_i;
  logic  periph_switch_ack_i = 1'b1;
  logic  exit_valid_o;
  word_t exit_value_o;
  gpio_t gpio_o;
  gpio_t gpio_oe_o;
  logic  periph_switch_o;
  logic  periph_iso_o;
  word_t intr_o;

  integer     seed = 69461;
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;
  int         chk_req = 0;
  int         chk_done = 0;
  gpio_t      gpio_stat_m = '0;
  logic       timer_irq_m = 1'b0;
  logic [1:0] sw_dly = 2'b11;

  mini_mcu_top UUT (.*);

  always #2 clk_i = ~clk_i;

  // Ack follows the switch three edges later
  always @(posedge clk_i) begin
    sw_dly <= {sw_dly[0], periph_switch_o};
    periph_switch_ack_i <= sw_dly[1];
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Reference positions: timer at bit 7, GPIO at bits 29:22
  function automatic word_t exp_intr(input gpio_t stat, input logic timer_irq);
    word_t v;
    v = '0;
    v[7] = timer_irq;
    v[29:22] = stat;
    return v;
  endfunction

  function automatic addr_t reg_addr(input region_t region, input word_t ofs);
    return (addr_t'(region) << REGION_LSB) | ofs;
  endfunction

  task automatic check_val(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Compare process for intr_o, served on the falling edge
  always @(negedge clk_i) begin
    if (chk_done != chk_req) begin
      check_val(intr_o, exp_intr(gpio_stat_m, timer_irq_m), "intr_o");
      chk_done = chk_req;
    end
  end

  task automatic check_intr();
    chk_req++;
    wait (chk_done == chk_req);
  endtask

  task automatic bus_access(input addr_t adr, input logic we, input word_t wdat,
                            output word_t rdat, output logic ack, output logic err);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    @(negedge clk_i);
    while (!(wb_ack_o || wb_err_o)) @(negedge clk_i);
    rdat = wb_dat_o;
    ack  = wb_ack_o;
    err  = wb_err_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic write_reg(input region_t region, input word_t ofs, input word_t data);
    word_t rd;
    logic  ack;
    logic  err;
    bus_access(reg_addr(region, ofs), 1'b1, data, rd, ack, err);
    check_val(word_t'(ack), 32'd1, "ack on write");
  endtask

  task automatic read_reg(input region_t region, input word_t ofs, output word_t data);
    logic ack;
    logic err;
    bus_access(reg_addr(region, ofs), 1'b0, '0, data, ack, err);
    check_val(word_t'(ack), 32'd1, "ack on read");
  endtask

  task automatic wait_power_state(input pwr_state_e target);
    word_t rd;
    int    n;
    rd = '1;
    n = 0;
    while (rd != word_t'(target) && n < 10) begin
      read_reg(REGION_AO_CTRL, PERIPH_POWER_OFS, rd);
      n++;
    end
    if (rd != word_t'(target)) begin
      errors++;
      $display("Power state did not reach %s within 10 reads", target.name());
    end
  endtask

  initial begin
    word_t rd;
    word_t val;
    word_t mask;
    word_t pins;
    word_t t0;
    logic  ack;
    logic  err;
    logic  boot;
    int    n;

    rst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    boot_select_i = 1'b0;
    gpio_i = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) @(posedge clk_i);

    // Register readback
    val = $random(seed);
    write_reg(REGION_AO_CTRL, EXIT_VALUE_OFS, val);
    read_reg(REGION_AO_CTRL, EXIT_VALUE_OFS, rd);
    check_val(rd, val, "EXIT_VALUE readback");
    check_val(exit_value_o, val, "exit_value_o");
    val = $random(seed);
    write_reg(REGION_GPIO, GPIO_OUT_OFS, val);
    read_reg(REGION_GPIO, GPIO_OUT_OFS, rd);
    check_val(rd, {24'b0, val[7:0]}, "GPIO_OUT readback");
    check_val(word_t'(gpio_o), {24'b0, val[7:0]}, "gpio_o");
    val = $random(seed);
    write_reg(REGION_GPIO, GPIO_OE_OFS, val);
    read_reg(REGION_GPIO, GPIO_OE_OFS, rd);
    check_val(rd, {24'b0, val[7:0]}, "GPIO_OE readback");
    check_val(word_t'(gpio_oe_o), {24'b0, val[7:0]}, "gpio_oe_o");
    boot = val[9];
    @(posedge clk_i);
    boot_select_i <= boot;
    read_reg(REGION_AO_CTRL, BOOT_SELECT_OFS, rd);
    check_val(rd, word_t'(boot), "BOOT_SELECT readback");
    // Both pin levels, so a stuck readback shows
    boot = ~boot;
    @(posedge clk_i);
    boot_select_i <= boot;
    read_reg(REGION_AO_CTRL, BOOT_SELECT_OFS, rd);
    check_val(rd, word_t'(boot), "BOOT_SELECT readback after toggle");
    bus_access(reg_addr(region_t'(5), '0), 1'b0, '0, rd, ack, err);
    check_val(word_t'(err), 32'd1, "err on region 5");
    check_val(word_t'(ack), 32'd0, "ack on region 5");

    check_val(word_t'(exit_valid_o), 32'd0, "exit_valid_o before write");
    write_reg(REGION_AO_CTRL, EXIT_VALID_OFS, 32'd1);
    check_val(word_t'(exit_valid_o), 32'd1, "exit_valid_o after write");

    // GPIO edges, at least one pin masked in and rising
    mask = $random(seed);
    mask = {24'b0, mask[7:0] | 8'h01};
    pins = $random(seed);
    pins = {24'b0, pins[7:0] | 8'h01};
    write_reg(REGION_GPIO, GPIO_INTR_EN_OFS, mask);
    check_intr();
    @(posedge clk_i);
    gpio_i <= pins[7:0];
    repeat (5) @(posedge clk_i);
    gpio_stat_m = mask[7:0] & pins[7:0];
    read_reg(REGION_GPIO, GPIO_INTR_STATUS_OFS, rd);
    check_val(rd, {24'b0, gpio_stat_m}, "GPIO_INTR_STATUS after edges");
    check_intr();
    write_reg(REGION_GPIO, GPIO_INTR_STATUS_OFS, {24'b0, gpio_stat_m});
    gpio_stat_m = '0;
    read_reg(REGION_GPIO, GPIO_INTR_STATUS_OFS, rd);
    check_val(rd, 32'd0, "GPIO_INTR_STATUS after clear");
    check_intr();

    // Timer
    t0 = $random(seed);
    t0 = t0 & 32'h0FFF_FFFF;
    write_reg(REGION_TIMER, MTIME_OFS, t0);
    read_reg(REGION_TIMER, MTIME_OFS, rd);
    check_val(rd, t0, "MTIME readback with count disabled");
    write_reg(REGION_TIMER, MTIMECMP_OFS, t0 + 32'd40);
    check_intr();
    write_reg(REGION_TIMER, TIMER_CTRL_OFS, 32'd3);
    n = 0;
    while (!intr_o[7] && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (!intr_o[7]) begin
      errors++;
      $display("Timer interrupt did not rise within 200 cycles");
    end
    read_reg(REGION_TIMER, MTIME_OFS, rd);
    check_val(word_t'(rd >= t0 + 32'd40), 32'd1, "MTIME at least MTIMECMP");
    timer_irq_m = 1'b1;
    check_intr();

    // Power down, isolation comes before the switch drops
    write_reg(REGION_AO_CTRL, PERIPH_POWER_OFS, 32'd0);
    n = 0;
    while (!periph_iso_o && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    check_val(word_t'(periph_iso_o), 32'd1, "periph_iso_o after power-down request");
    check_val(word_t'(periph_switch_o), 32'd1, "periph_switch_o as isolation rises");
    n = 0;
    while (periph_switch_o && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    check_val(word_t'(periph_switch_o), 32'd0, "periph_switch_o after isolation");
    wait_power_state(OFF);
    bus_access(reg_addr(REGION_TIMER, MTIME_OFS), 1'b0, '0, rd, ack, err);
    check_val(word_t'(err), 32'd1, "err on timer access while off");
    check_val(word_t'(ack), 32'd0, "ack on timer access while off");
    timer_irq_m = 1'b0;
    check_intr();

    // Wake up, timer comes back from its domain reset
    write_reg(REGION_AO_CTRL, PERIPH_POWER_OFS, 32'd1);
    wait_power_state(ON);
    check_val(word_t'(periph_iso_o), 32'd0, "periph_iso_o after wake-up");
    check_val(word_t'(periph_switch_o), 32'd1, "periph_switch_o after wake-up");
    read_reg(REGION_TIMER, MTIME_OFS, rd);
    check_val(rd, 32'd0, "MTIME after power cycle");
    read_reg(REGION_TIMER, MTIMECMP_OFS, rd);
    check_val(rd, 32'd0, "MTIMECMP after power cycle");
    read_reg(REGION_TIMER, TIMER_CTRL_OFS, rd);
    check_val(rd, 32'd0, "TIMER_CTRL after power cycle");
    check_intr();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: hw/mini_mcu_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Always-on control corner with a Wishbone host port in place of a CPU
// Timer interrupt is clamped low while the peripheral domain is isolated
// ~~~~~~~~~~~~~~~~~~~~
module mini_mcu_top
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  word_t wb_dat_i,
  output word_t wb_dat_o,
  output logic  wb_ack_o,
  output logic  wb_err_o,
  input  logic  boot_select_i,
  input  gpio_t gpio_i,
  input  logic  periph_switch_ack_i,
  output logic  exit_valid_o,
  output word_t exit_value_o,
  output gpio_t gpio_o,
  output gpio_t gpio_oe_o,
  output logic  periph_switch_o,
  output logic  periph_iso_o,
  output word_t intr_o
);

  logic  ao_sel;
  logic  gpio_sel;
  logic  timer_sel;
  logic  we;
  word_t ofs;
  word_t wdata;
  word_t ao_rdata;
  word_t gpio_rdata;
  word_t timer_rdata;
  logic  periph_on;
  logic  periph_rst_n;
  logic  periph_clk_en;
  gpio_t gpio_intr;
  logic  timer_intr;

  wb_decoder wb_decoder_i (
    .clk_i,
    .rst_n_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o,
    .periph_on_i  (periph_on),
    .ao_sel_o     (ao_sel),
    .gpio_sel_o   (gpio_sel),
    .timer_sel_o  (timer_sel),
    .we_o         (we),
    .ofs_o        (ofs),
    .wdata_o      (wdata),
    .ao_rdata_i   (ao_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata)
  );

  ao_ctrl_regs ao_ctrl_regs_i (
    .clk_i,
    .rst_n_i,
    .sel_i          (ao_sel),
    .we_i           (we),
    .ofs_i          (ofs),
    .wdata_i        (wdata),
    .boot_select_i,
    .periph_switch_ack_i,
    .rdata_o        (ao_rdata),
    .exit_valid_o,
    .exit_value_o,
    .periph_switch_o,
    .periph_iso_o,
    .periph_rst_n_o (periph_rst_n),
    .periph_clk_en_o(periph_clk_en),
    .periph_on_o    (periph_on)
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .sel_i    (gpio_sel),
    .we_i     (we),
    .ofs_i    (ofs),
    .wdata_i  (wdata),
    .gpio_i,
    .rdata_o  (gpio_rdata),
    .gpio_o,
    .gpio_oe_o,
    .intr_o   (gpio_intr)
  );

  // Timer runs from the domain reset and clock enable
  rv_timer rv_timer_i (
    .clk_i,
    .rst_n_i (periph_rst_n),
    .clk_en_i(periph_clk_en),
    .sel_i   (timer_sel),
    .we_i    (we),
    .ofs_i   (ofs),
    .wdata_i (wdata),
    .rdata_o (timer_rdata),
    .intr_o  (timer_intr)
  );

  always_comb begin
    intr_o = '0;
    intr_o[INTR_TIMER_BIT] = timer_intr & ~periph_iso_o;
    intr_o[INTR_GPIO_LSB+:NUM_GPIO] = gpio_intr;
  end

endmodule

// File: hw/rv_timer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Machine timer in the switchable domain, 32-bit mtime that wraps
// All state is lost while the domain reset is held
// ~~~~~~~~~~~~~~~~~~~~
module rv_timer
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  clk_en_i,
  input  logic  sel_i,
  input  logic  we_i,
  input  word_t ofs_i,
  input  word_t wdata_i,
  output word_t rdata_o,
  output logic  intr_o
);

  word_t mtime_q;
  word_t mtimecmp_q;
  logic  cnt_en_q;
  logic  irq_en_q;
  logic  wr;

  assign wr = sel_i & we_i;

  // Clock enable freezes the whole block, as a gated clock would
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '0;
      cnt_en_q   <= 1'b0;
      irq_en_q   <= 1'b0;
    end else if (clk_en_i) begin
      if (wr && ofs_i == MTIME_OFS) begin
        mtime_q <= wdata_i;
      end else if (cnt_en_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr && ofs_i == MTIMECMP_OFS) mtimecmp_q <= wdata_i;
      if (wr && ofs_i == TIMER_CTRL_OFS) begin
        cnt_en_q <= wdata_i[0];
        irq_en_q <= wdata_i[1];
      end
    end
  end

  assign intr_o = irq_en_q & (mtime_q >= mtimecmp_q);

  always_comb begin
    case (ofs_i)
      MTIME_OFS:      rdata_o = mtime_q;
      MTIMECMP_OFS:   rdata_o = mtimecmp_q;
      TIMER_CTRL_OFS: rdata_o = {30'b0, irq_en_q, cnt_en_q};
      default:        rdata_o = '0;
    endcase
  end

endmodule

// File: hw/gpio_ao.sv
// ~~~~~~~~~~~~~~~~~~~~
// Always-on GPIO, pins are asynchronous and pass a two-flop synchronizer
// Rising-edge interrupts only; status is write one to clear
// ~~~~~~~~~~~~~~~~~~~~
module gpio_ao
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  sel_i,
  input  logic  we_i,
  input  word_t ofs_i,
  input  word_t wdata_i,
  input  gpio_t gpio_i,
  output word_t rdata_o,
  output gpio_t gpio_o,
  output gpio_t gpio_oe_o,
  output gpio_t intr_o
);

  gpio_t sync1_q;
  gpio_t sync2_q;
  gpio_t prev_q;
  gpio_t intr_en_q;
  gpio_t rise;
  gpio_t clr;
  logic  wr;

  assign wr   = sel_i & we_i;
  assign rise = sync2_q & ~prev_q;
  assign clr  = (wr && ofs_i == GPIO_INTR_STATUS_OFS) ? wdata_i[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o    <= '0;
      gpio_oe_o <= '0;
      intr_en_q <= '0;
      intr_o    <= '0;
    end else begin
      if (wr && ofs_i == GPIO_OUT_OFS) gpio_o <= wdata_i[NUM_GPIO-1:0];
      if (wr && ofs_i == GPIO_OE_OFS) gpio_oe_o <= wdata_i[NUM_GPIO-1:0];
      if (wr && ofs_i == GPIO_INTR_EN_OFS) intr_en_q <= wdata_i[NUM_GPIO-1:0];
      // A new edge wins over a clear in the same cycle
      intr_o <= (intr_o & ~clr) | (rise & intr_en_q);
    end
  end

  always_comb begin
    case (ofs_i)
      GPIO_IN_OFS:          rdata_o = word_t'(sync2_q);
      GPIO_OUT_OFS:         rdata_o = word_t'(gpio_o);
      GPIO_OE_OFS:          rdata_o = word_t'(gpio_oe_o);
      GPIO_INTR_EN_OFS:     rdata_o = word_t'(intr_en_q);
      GPIO_INTR_STATUS_OFS: rdata_o = word_t'(intr_o);
      default:              rdata_o = '0;
    endcase
  end

endmodule

// File: hw/ao_ctrl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Exit, boot and power registers for the switchable peripheral domain
// Power-down waits for the switch ack to fall, wake-up for it to rise
// ~~~~~~~~~~~~~~~~~~~~
module ao_ctrl_regs
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  sel_i,
  input  logic  we_i,
  input  word_t ofs_i,
  input  word_t wdata_i,
  input  logic  boot_select_i,
  input  logic  periph_switch_ack_i,
  output word_t rdata_o,
  output logic  exit_valid_o,
  output word_t exit_value_o,
  output logic  periph_switch_o,
  output logic  periph_iso_o,
  output logic  periph_rst_n_o,
  output logic  periph_clk_en_o,
  output logic  periph_on_o
);

  pwr_state_e state_q;
  logic       pwr_req_q;
  logic       wr;

  assign wr = sel_i & we_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      pwr_req_q    <= 1'b1;
    end else if (wr) begin
      if (ofs_i == EXIT_VALID_OFS) exit_valid_o <= wdata_i[0];
      if (ofs_i == EXIT_VALUE_OFS) exit_value_o <= wdata_i;
      if (ofs_i == PERIPH_POWER_OFS) pwr_req_q <= wdata_i[0];
    end
  end

  // Domain reset is held during system reset and released in ON
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q         <= ON;
      periph_switch_o <= 1'b1;
      periph_iso_o    <= 1'b0;
      periph_rst_n_o  <= 1'b0;
      periph_clk_en_o <= 1'b1;
    end else begin
      case (state_q)
        ON: begin
          periph_rst_n_o <= 1'b1;
          if (!pwr_req_q) begin
            periph_iso_o    <= 1'b1;
            periph_clk_en_o <= 1'b0;
            state_q         <= ISO;
          end
        end
        ISO: begin
          // Switch drops one cycle after isolation
          periph_switch_o <= 1'b0;
          periph_rst_n_o  <= 1'b0;
          if (!periph_switch_o && !periph_switch_ack_i) state_q <= OFF;
        end
        OFF: begin
          if (pwr_req_q) begin
            periph_switch_o <= 1'b1;
            state_q         <= WAKE;
          end
        end
        WAKE: begin
          if (periph_switch_ack_i) begin
            periph_rst_n_o  <= 1'b1;
            periph_clk_en_o <= 1'b1;
            periph_iso_o    <= 1'b0;
            state_q         <= ON;
          end
        end
        default: state_q <= ON;
      endcase
    end
  end

  assign periph_on_o = (state_q == ON);

  always_comb begin
    case (ofs_i)
      EXIT_VALID_OFS:   rdata_o = word_t'(exit_valid_o);
      EXIT_VALUE_OFS:   rdata_o = exit_value_o;
      BOOT_SELECT_OFS:  rdata_o = word_t'(boot_select_i);
      PERIPH_POWER_OFS: rdata_o = word_t'(state_q);
      default:          rdata_o = '0;
    endcase
  end

endmodule

// File: hw/wb_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave, full-word accesses only, one access in flight
// Answer comes one cycle after the request and is not repeated until stb drops
// ~~~~~~~~~~~~~~~~~~~~
module wb_decoder
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  word_t wb_dat_i,
  output word_t wb_dat_o,
  output logic  wb_ack_o,
  output logic  wb_err_o,
  input  logic  periph_on_i,
  output logic  ao_sel_o,
  output logic  gpio_sel_o,
  output logic  timer_sel_o,
  output logic  we_o,
  output word_t ofs_o,
  output word_t wdata_o,
  input  word_t ao_rdata_i,
  input  word_t gpio_rdata_i,
  input  word_t timer_rdata_i
);

  region_t region;
  logic    req;
  logic    done_q;
  logic    hit;
  word_t   rdata_mux;

  assign region = wb_adr_i[REGION_LSB+REGION_W-1:REGION_LSB];

  // New request only once the previous one has seen stb drop
  assign req = wb_cyc_i & wb_stb_i & ~done_q;

  assign ao_sel_o    = req & (region == REGION_AO_CTRL);
  assign gpio_sel_o  = req & (region == REGION_GPIO);
  assign timer_sel_o = req & (region == REGION_TIMER) & periph_on_i;
  assign hit         = ao_sel_o | gpio_sel_o | timer_sel_o;

  assign we_o    = wb_we_i;
  assign ofs_o   = {{(32-REGION_LSB){1'b0}}, wb_adr_i[REGION_LSB-1:0]};
  assign wdata_o = wb_dat_i;

  always_comb begin
    rdata_mux = '0;
    if (ao_sel_o) rdata_mux = ao_rdata_i;
    if (gpio_sel_o) rdata_mux = gpio_rdata_i;
    if (timer_sel_o) rdata_mux = timer_rdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q   <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      done_q   <= wb_cyc_i & wb_stb_i;
      wb_ack_o <= req & hit;
      wb_err_o <= req & ~hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) wb_dat_o <= rdata_mux;
  end

endmodule

// File: hw/mcu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Constants and types shared by the MCU control corner
// Address bits above the region field are not decoded, so the map aliases
// ~~~~~~~~~~~~~~~~~~~~
package mcu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  localparam int NUM_GPIO = 8;
  typedef logic [NUM_GPIO-1:0] gpio_t;

  // Region field sits at address bits 15:12
  localparam int REGION_LSB = 12;
  localparam int REGION_W = 4;
  typedef logic [REGION_W-1:0] region_t;

  localparam region_t REGION_AO_CTRL = 4'd0;
  localparam region_t REGION_GPIO = 4'd1;
  localparam region_t REGION_TIMER = 4'd2;

  localparam word_t EXIT_VALID_OFS = 32'h0;
  localparam word_t EXIT_VALUE_OFS = 32'h4;
  localparam word_t BOOT_SELECT_OFS = 32'h8;
  localparam word_t PERIPH_POWER_OFS = 32'hC;

  localparam word_t GPIO_IN_OFS = 32'h0;
  localparam word_t GPIO_OUT_OFS = 32'h4;
  localparam word_t GPIO_OE_OFS = 32'h8;
  localparam word_t GPIO_INTR_EN_OFS = 32'hC;
  localparam word_t GPIO_INTR_STATUS_OFS = 32'h10;

  localparam word_t MTIME_OFS = 32'h0;
  localparam word_t MTIMECMP_OFS = 32'h4;
  localparam word_t TIMER_CTRL_OFS = 32'h8;

  localparam int INTR_TIMER_BIT = 7;
  localparam int INTR_GPIO_LSB = 22;

  typedef enum logic [1:0] {
    ON   = 2'd0,
    ISO  = 2'd1,
    OFF  = 2'd2,
    WAKE = 2'd3
  } pwr_state_e;

endpackage
